/* Makefile */
# Verilator flow for the pcore_lsu subsystem

VERILATOR ?= verilator
TOP       ?= tb_pcore_lsu
RTL_TOP   ?= pcore_lsu_top
FILELIST  ?= pcore_lsu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/pcore_lsu_cfg.svh */
`ifndef PCORE_LSU_CFG_SVH
`define PCORE_LSU_CFG_SVH

// Data and address width
`define XLEN 32

// Upstream credits, also the execute request queue depth
`define LSU_REQ_CREDITS 2

// Memory link credits, also the dmem request buffer depth
`define DMEM_CREDITS 2

// Word-address bits of the data memory
`define DMEM_DEPTH_LOG2 8

// In-flight metadata queue depth
// Must cover DMEM_CREDITS plus the issue and ack stages
`define LSU_INFLIGHT 4

`endif

/* pcore_lsu.f */
+incdir+include
src/lsu_pkg.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/lsu_result.sv
src/dmem.sv
src/pcore_lsu_top.sv
verif/tb_pcore_lsu.sv

/* src/dmem.sv */
`timescale 1ns/1ps
`include "pcore_lsu_cfg.svh"

module dmem (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  lsu_pkg::lsu2dbus_s  dbus_i,
   input  logic                stall_i,
   output logic                credit_o,
   output lsu_pkg::dbus2lsu_s  dbus_o
);

   localparam int BDEPTH = `DMEM_CREDITS;
   localparam int WORDS  = 1 << `DMEM_DEPTH_LOG2;
   localparam int PTR_W  = (BDEPTH > 1) ? $clog2(BDEPTH) : 1;
   localparam int CNT_W  = $clog2(BDEPTH + 1);

   logic [`XLEN-1:0]              mem_q [WORDS];
   lsu_pkg::lsu2dbus_s            buf_q [BDEPTH];
   lsu_pkg::lsu2dbus_s            head;
   logic [PTR_W-1:0]              wr_ptr_q;
   logic [PTR_W-1:0]              rd_ptr_q;
   logic [CNT_W-1:0]              count_q;
   logic                          pop;
   logic [`DMEM_DEPTH_LOG2-1:0]   waddr;
   logic                          ack_q;
   lsu_pkg::dbus_word_u           r_data_q;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(BDEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign head  = buf_q[rd_ptr_q];
   assign pop   = (count_q != '0) && !stall_i;
   assign waddr = head.addr[`DMEM_DEPTH_LOG2+1:2];

   // Request buffer, kept from overflow by the credit scheme
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (dbus_i.valid) begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         count_q <= count_q + CNT_W'(dbus_i.valid) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk_i) begin
      if (dbus_i.valid) begin
         buf_q[wr_ptr_q] <= dbus_i;
      end
   end

   // Byte-masked write of the popped request
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < WORDS; i++) begin
            mem_q[i] <= '0;
         end
      end else if (pop && head.wr) begin
         for (int b = 0; b < 4; b++) begin
            if (head.byte_en[b]) begin
               mem_q[waddr][b*8 +: 8] <= head.w_data.bytes[b];
            end
         end
      end
   end

   // Response carries the word as it was before the write
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= pop;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pop) begin
         r_data_q.word <= mem_q[waddr];
      end
   end

   assign credit_o      = pop;
   assign dbus_o.ack    = ack_q;
   assign dbus_o.r_data = r_data_q;

endmodule

/* src/lsu_decode.sv */
`timescale 1ns/1ps

module lsu_decode (
   input  lsu_pkg::exe2lsu_s   req_i,
   output lsu_pkg::lsu2dbus_s  dbus_o,
   output lsu_pkg::lsu_meta_s  meta_o
);

   logic                 is_half;
   logic                 is_word;
   logic                 is_store;
   logic                 misaligned;
   logic [1:0]           byte_off;
   logic [3:0]           byte_en;
   lsu_pkg::dbus_word_u  st_data;

   assign byte_off = req_i.addr[1:0];
   assign is_store = (req_i.st_ops != lsu_pkg::ST_NONE);

   assign is_half = (req_i.ld_ops == lsu_pkg::LH) ||
                    (req_i.ld_ops == lsu_pkg::LHU) ||
                    (req_i.st_ops == lsu_pkg::SH);

   assign is_word = (req_i.ld_ops == lsu_pkg::LW) ||
                    (req_i.st_ops == lsu_pkg::SW);

   // Halfword on an odd byte, or word off a word boundary
   assign misaligned = (is_half && byte_off[0]) ||
                       (is_word && (byte_off != 2'b00));

   // Lane placement and byte enables
   always_comb begin
      byte_en      = 4'b0000;
      st_data.word = req_i.w_data;
      case (req_i.st_ops)
         lsu_pkg::SB: begin
            byte_en = 4'b0001 << byte_off;
            for (int i = 0; i < 4; i++) begin
               st_data.bytes[i] = req_i.w_data[7:0];
            end
         end
         lsu_pkg::SH: begin
            byte_en          = byte_off[1] ? 4'b1100 : 4'b0011;
            st_data.hword[0] = req_i.w_data[15:0];
            st_data.hword[1] = req_i.w_data[15:0];
         end
         lsu_pkg::SW: begin
            byte_en = 4'b1111;
         end
         default: begin
            byte_en = 4'b0000;
         end
      endcase
      // No lanes are written for a bad address
      if (misaligned) begin
         byte_en = 4'b0000;
      end
   end

   assign dbus_o.valid   = req_i.valid;
   assign dbus_o.addr    = req_i.addr;
   assign dbus_o.w_data  = st_data;
   assign dbus_o.byte_en = byte_en;
   assign dbus_o.wr      = is_store && !misaligned;

   assign meta_o.ld_ops     = req_i.ld_ops;
   assign meta_o.rd_addr    = req_i.rd_addr;
   assign meta_o.byte_off   = byte_off;
   assign meta_o.misaligned = misaligned;

endmodule

/* src/lsu_execute.sv */
`timescale 1ns/1ps
`include "pcore_lsu_cfg.svh"

module lsu_execute (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  lsu_pkg::exe2lsu_s   req_i,
   output logic                exe_credit_o,
   input  logic                dmem_credit_i,
   output lsu_pkg::lsu2dbus_s  dbus_o,
   output logic                issue_o,
   output lsu_pkg::lsu_meta_s  meta_o
);

   localparam int QDEPTH = `LSU_REQ_CREDITS;
   localparam int PTR_W  = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
   localparam int CNT_W  = $clog2(QDEPTH + 1);
   localparam int CRD_W  = $clog2(`DMEM_CREDITS + 1);

   lsu_pkg::lsu2dbus_s  dec_bus;
   lsu_pkg::lsu_meta_s  dec_meta;
   lsu_pkg::lsu2dbus_s  bus_q  [QDEPTH];
   lsu_pkg::lsu_meta_s  meta_q [QDEPTH];

   logic [PTR_W-1:0]    wr_ptr_q;
   logic [PTR_W-1:0]    rd_ptr_q;
   logic [CNT_W-1:0]    count_q;
   logic [CRD_W-1:0]    credits_q;
   logic                push;
   logic                issue;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(QDEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   lsu_decode u_decode (
      .req_i  (req_i),
      .dbus_o (dec_bus),
      .meta_o (dec_meta)
   );

   // Sender holds a credit for every valid beat, so no full check
   assign push  = dec_bus.valid;
   assign issue = (count_q != '0) && (credits_q != '0);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (issue) begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         count_q <= count_q + CNT_W'(push) - CNT_W'(issue);
      end
   end

   // Queue storage
   always_ff @(posedge clk_i) begin
      if (push) begin
         bus_q[wr_ptr_q]  <= dec_bus;
         meta_q[wr_ptr_q] <= dec_meta;
      end
   end

   // Memory credits, spent on issue and restored by dmem
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         credits_q <= CRD_W'(`DMEM_CREDITS);
      end else begin
         credits_q <= credits_q - CRD_W'(issue) + CRD_W'(dmem_credit_i);
      end
   end

   always_comb begin
      dbus_o       = bus_q[rd_ptr_q];
      dbus_o.valid = issue;
   end

   assign meta_o  = meta_q[rd_ptr_q];
   assign issue_o = issue;

   // A queue slot frees up on every issue
   assign exe_credit_o = issue;

endmodule

/* src/lsu_pkg.sv */
`include "pcore_lsu_cfg.svh"

package lsu_pkg;

   // Load kinds
   typedef enum logic [2:0] {
      LD_NONE,
      LB,
      LBU,
      LH,
      LHU,
      LW
   } ld_ops_e;

   // Store kinds
   typedef enum logic [1:0] {
      ST_NONE,
      SB,
      SH,
      SW
   } st_ops_e;

   // Request from the execute stage
   typedef struct packed {
      logic              valid;
      ld_ops_e           ld_ops;
      st_ops_e           st_ops;
      logic [4:0]        rd_addr;
      logic [`XLEN-1:0]  addr;
      logic [`XLEN-1:0]  w_data;
   } exe2lsu_s;

   // One bus word with its halfword and byte lane views
   typedef union packed {
      logic [`XLEN-1:0]  word;
      logic [1:0][15:0]  hword;
      logic [3:0][7:0]   bytes;
   } dbus_word_u;

   // LSU to data memory
   typedef struct packed {
      logic              valid;
      logic [`XLEN-1:0]  addr;
      dbus_word_u        w_data;
      logic [3:0]        byte_en;
      logic              wr;
   } lsu2dbus_s;

   // Data memory response
   typedef struct packed {
      logic              ack;
      dbus_word_u        r_data;
   } dbus2lsu_s;

   // Per-access data kept until the ack
   typedef struct packed {
      ld_ops_e           ld_ops;
      logic [4:0]        rd_addr;
      logic [1:0]        byte_off;
      logic              misaligned;
   } lsu_meta_s;

   // Writeback record
   typedef struct packed {
      logic              valid;
      logic [4:0]        rd_addr;
      logic              rd_wr_req;
      logic [`XLEN-1:0]  r_data;
      logic              misaligned;
   } lsu2wrb_s;

endpackage

/* src/lsu_result.sv */
`timescale 1ns/1ps
`include "pcore_lsu_cfg.svh"

module lsu_result (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                issue_i,
   input  lsu_pkg::lsu_meta_s  meta_i,
   input  lsu_pkg::dbus2lsu_s  dbus_i,
   output lsu_pkg::lsu2wrb_s   wrb_o
);

   localparam int QDEPTH = `LSU_INFLIGHT;
   localparam int PTR_W  = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;

   lsu_pkg::lsu_meta_s  meta_q [QDEPTH];
   lsu_pkg::lsu_meta_s  head;
   logic [PTR_W-1:0]    wr_ptr_q;
   logic [PTR_W-1:0]    rd_ptr_q;
   logic [7:0]          ld_byte;
   logic [15:0]         ld_hword;
   logic [`XLEN-1:0]    ld_data;
   logic                wr_req;

   logic                wrb_valid_q;
   logic [4:0]          rd_addr_q;
   logic                rd_wr_req_q;
   logic [`XLEN-1:0]    r_data_q;
   logic                misaligned_q;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(QDEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Acks return in issue order, so the head matches the ack
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (issue_i) begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (dbus_i.ack) begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (issue_i) begin
         meta_q[wr_ptr_q] <= meta_i;
      end
   end

   assign head = meta_q[rd_ptr_q];

   // Lane pick and sign or zero extension
   always_comb begin
      ld_byte  = dbus_i.r_data.bytes[head.byte_off];
      ld_hword = dbus_i.r_data.hword[head.byte_off[1]];
      case (head.ld_ops)
         lsu_pkg::LB:  ld_data = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
         lsu_pkg::LBU: ld_data = {{(`XLEN-8){1'b0}}, ld_byte};
         lsu_pkg::LH:  ld_data = {{(`XLEN-16){ld_hword[15]}}, ld_hword};
         lsu_pkg::LHU: ld_data = {{(`XLEN-16){1'b0}}, ld_hword};
         lsu_pkg::LW:  ld_data = dbus_i.r_data.word;
         default:      ld_data = '0;
      endcase
      if (head.misaligned) begin
         ld_data = '0;
      end
   end

   // x0 is never written
   assign wr_req = (head.ld_ops != lsu_pkg::LD_NONE) && !head.misaligned &&
                   (head.rd_addr != 5'd0);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wrb_valid_q <= 1'b0;
      end else begin
         wrb_valid_q <= dbus_i.ack;
      end
   end

   always_ff @(posedge clk_i) begin
      if (dbus_i.ack) begin
         rd_addr_q    <= head.rd_addr;
         rd_wr_req_q  <= wr_req;
         r_data_q     <= ld_data;
         misaligned_q <= head.misaligned;
      end
   end

   assign wrb_o.valid      = wrb_valid_q;
   assign wrb_o.rd_addr    = rd_addr_q;
   assign wrb_o.rd_wr_req  = rd_wr_req_q;
   assign wrb_o.r_data     = r_data_q;
   assign wrb_o.misaligned = misaligned_q;

endmodule

/* src/pcore_lsu_top.sv */
`timescale 1ns/1ps

module pcore_lsu_top (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  lsu_pkg::exe2lsu_s  exe2lsu_i,
   output logic               exe_credit_o,
   input  logic               dmem_stall_i,
   output lsu_pkg::lsu2wrb_s  wrb_o
);

   lsu_pkg::lsu2dbus_s  lsu2dbus;
   lsu_pkg::dbus2lsu_s  dbus2lsu;
   lsu_pkg::lsu_meta_s  issue_meta;
   logic                issue;
   logic                dmem_credit;

   // Queueing and issue to memory
   lsu_execute u_execute (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_i         (exe2lsu_i),
      .exe_credit_o  (exe_credit_o),
      .dmem_credit_i (dmem_credit),
      .dbus_o        (lsu2dbus),
      .issue_o       (issue),
      .meta_o        (issue_meta)
   );

   // Load data formatting and writeback
   lsu_result u_result (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .issue_i (issue),
      .meta_i  (issue_meta),
      .dbus_i  (dbus2lsu),
      .wrb_o   (wrb_o)
   );

   dmem u_dmem (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .dbus_i   (lsu2dbus),
      .stall_i  (dmem_stall_i),
      .credit_o (dmem_credit),
      .dbus_o   (dbus2lsu)
   );

endmodule

/* verif/tb_pcore_lsu.sv */
`timescale 1ns/1ps
`include "pcore_lsu_cfg.svh"

module tb_pcore_lsu;

   localparam int TIMEOUT = 200;

   // Expected writeback of one access
   typedef struct packed {
      logic         is_load;
      logic         mis;
      logic         wr_req;
      logic [4:0]   rd;
      logic [31:0]  data;
   } exp_s;

   logic                clk_i;
   logic                rst_n_i;
   lsu_pkg::exe2lsu_s   exe2lsu_i;
   logic                exe_credit_o;
   logic                dmem_stall_i;
   lsu_pkg::lsu2wrb_s   wrb_o;

   logic [7:0]          ref_mem [1024];
   exp_s                exp_q [$];
   lsu_pkg::lsu2wrb_s   wrb_q [$];
   int                  credit_cnt;
   int                  credit_returns;
   int                  errors;
   int                  test_base;
   int                  tests_run;
   string               cur_test;
   logic [31:0]         lcg_state;
   logic [7:0]          bvals [4];

   pcore_lsu_top u_dut (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .exe2lsu_i    (exe2lsu_i),
      .exe_credit_o (exe_credit_o),
      .dmem_stall_i (dmem_stall_i),
      .wrb_o        (wrb_o)
   );

   always #4 clk_i = ~clk_i;

   // Outputs are settled by the falling edge
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         if (exe_credit_o) begin
            credit_cnt++;
            credit_returns++;
            if (credit_cnt > `LSU_REQ_CREDITS) begin
               $display("Credit overflow in %s: more credits came back than were spent",
                        cur_test);
               errors++;
            end
         end
         if (wrb_o.valid) begin
            wrb_q.push_back(wrb_o);
         end
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Reference behavior of one access, applied to the byte memory in order
   function automatic exp_s model_access(input lsu_pkg::ld_ops_e ld, input lsu_pkg::st_ops_e st,
                                         input logic [4:0] rd, input logic [31:0] addr,
                                         input logic [31:0] data);
      exp_s         e;
      logic [9:0]   a;
      logic [7:0]   b;
      logic [15:0]  h;
      logic [31:0]  w;
      logic         half;
      logic         word;
      a    = addr[9:0];
      half = (ld == lsu_pkg::LH) || (ld == lsu_pkg::LHU) || (st == lsu_pkg::SH);
      word = (ld == lsu_pkg::LW) || (st == lsu_pkg::SW);
      b    = ref_mem[a];
      h    = {ref_mem[a + 10'd1], ref_mem[a]};
      w    = {ref_mem[a + 10'd3], ref_mem[a + 10'd2], h};
      e.rd      = rd;
      e.is_load = (ld != lsu_pkg::LD_NONE);
      e.mis     = (half && a[0]) || (word && (a[1:0] != 2'b00));
      e.data    = '0;
      e.wr_req  = 1'b0;
      if (!e.mis) begin
         case (ld)
            lsu_pkg::LB:  e.data = {{24{b[7]}}, b};
            lsu_pkg::LBU: e.data = {24'd0, b};
            lsu_pkg::LH:  e.data = {{16{h[15]}}, h};
            lsu_pkg::LHU: e.data = {16'd0, h};
            lsu_pkg::LW:  e.data = w;
            default:      e.data = '0;
         endcase
         e.wr_req = e.is_load && (rd != 5'd0);
         case (st)
            lsu_pkg::SB: ref_mem[a] = data[7:0];
            lsu_pkg::SH: begin
               ref_mem[a]         = data[7:0];
               ref_mem[a + 10'd1] = data[15:8];
            end
            lsu_pkg::SW: begin
               for (int i = 0; i < 4; i++) begin
                  ref_mem[a + 10'(i)] = data[i*8 +: 8];
               end
            end
            default: ;
         endcase
      end
      return e;
   endfunction

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic send_req(input lsu_pkg::ld_ops_e ld, input lsu_pkg::st_ops_e st,
                           input logic [4:0] rd, input logic [31:0] addr,
                           input logic [31:0] data);
      int waited;
      waited = 0;
      while (credit_cnt == 0 && waited < TIMEOUT) begin
         idle(1);
         waited++;
      end
      if (credit_cnt == 0) begin
         $display("Timeout in %s: no upstream credit came back", cur_test);
         errors++;
         return;
      end
      exe2lsu_i.valid   = 1'b1;
      exe2lsu_i.ld_ops  = ld;
      exe2lsu_i.st_ops  = st;
      exe2lsu_i.rd_addr = rd;
      exe2lsu_i.addr    = addr;
      exe2lsu_i.w_data  = data;
      credit_cnt--;
      exp_q.push_back(model_access(ld, st, rd, addr, data));
      idle(1);
      exe2lsu_i.valid = 1'b0;
   endtask

   task automatic check_wrb(input exp_s e, input lsu_pkg::lsu2wrb_s w);
      if (w.misaligned !== e.mis) begin
         $display("Mismatch in %s: misaligned expected %0b actual %0b",
                  cur_test, e.mis, w.misaligned);
         errors++;
      end
      if (w.rd_wr_req !== e.wr_req) begin
         $display("Mismatch in %s: rd_wr_req expected %0b actual %0b",
                  cur_test, e.wr_req, w.rd_wr_req);
         errors++;
      end
      if ((e.is_load || e.mis) && (w.r_data !== e.data)) begin
         $display("Mismatch in %s: r_data expected %h actual %h", cur_test, e.data, w.r_data);
         errors++;
      end
      if (e.is_load && (w.rd_addr !== e.rd)) begin
         $display("Mismatch in %s: rd_addr expected %0d actual %0d", cur_test, e.rd, w.rd_addr);
         errors++;
      end
   endtask

   // Pairs each writeback with the oldest expected entry
   task automatic drain_wrb;
      exp_s               e;
      lsu_pkg::lsu2wrb_s  w;
      int                 waited;
      while (exp_q.size() > 0) begin
         waited = 0;
         while (wrb_q.size() == 0 && waited < TIMEOUT) begin
            idle(1);
            waited++;
         end
         if (wrb_q.size() == 0) begin
            $display("Timeout in %s: writeback did not arrive, %0d still outstanding",
                     cur_test, exp_q.size());
            errors++;
            exp_q.delete();
            return;
         end
         e = exp_q.pop_front();
         w = wrb_q.pop_front();
         check_wrb(e, w);
      end
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_base = errors;
   endtask

   task automatic end_test;
      idle(4);
      if (wrb_q.size() != 0) begin
         $display("Unexpected writeback in %s: %0d more than requests sent",
                  cur_test, wrb_q.size());
         errors++;
         wrb_q.delete();
      end
      tests_run++;
      $display("Test %-10s finished with %0d errors", cur_test, errors - test_base);
   endtask

   task automatic test_reset;
      start_test("reset");
      idle(10);
      if (wrb_q.size() != 0 || credit_returns != 0) begin
         $display("Activity in %s: writeback or credit seen with no requests", cur_test);
         errors++;
      end
      end_test();
   endtask

   task automatic test_word;
      start_test("word");
      for (int i = 0; i < 4; i++) begin
         send_req(lsu_pkg::LD_NONE, lsu_pkg::SW, 5'd0, 32'h40 + i * 4, 32'hA5A5_0F00 + i * 17);
      end
      for (int i = 0; i < 4; i++) begin
         send_req(lsu_pkg::LW, lsu_pkg::ST_NONE, 5'(i + 1), 32'h40 + i * 4, 32'd0);
      end
      drain_wrb();
      end_test();
   endtask

   task automatic test_subword;
      start_test("subword");
      // Upper data bits are noise that must not reach memory
      for (int i = 0; i < 4; i++) begin
         send_req(lsu_pkg::LD_NONE, lsu_pkg::SB, 5'd0, 32'h80 + i, {24'hEEEEEE, bvals[i]});
      end
      for (int i = 0; i < 4; i++) begin
         send_req(lsu_pkg::LB, lsu_pkg::ST_NONE, 5'(10 + i), 32'h80 + i, 32'd0);
         send_req(lsu_pkg::LBU, lsu_pkg::ST_NONE, 5'(20 + i), 32'h80 + i, 32'd0);
      end
      send_req(lsu_pkg::LD_NONE, lsu_pkg::SH, 5'd0, 32'h90, 32'h1234_8001);
      send_req(lsu_pkg::LD_NONE, lsu_pkg::SH, 5'd0, 32'h92, 32'hFFFF_7FFE);
      for (int i = 0; i < 2; i++) begin
         send_req(lsu_pkg::LH, lsu_pkg::ST_NONE, 5'd11, 32'h90 + i * 2, 32'd0);
         send_req(lsu_pkg::LHU, lsu_pkg::ST_NONE, 5'd12, 32'h90 + i * 2, 32'd0);
      end
      send_req(lsu_pkg::LW, lsu_pkg::ST_NONE, 5'd13, 32'h90, 32'd0);
      // Load to x0
      send_req(lsu_pkg::LB, lsu_pkg::ST_NONE, 5'd0, 32'h81, 32'd0);
      drain_wrb();
      end_test();
   endtask

   task automatic test_misaligned;
      start_test("misaligned");
      send_req(lsu_pkg::LD_NONE, lsu_pkg::SW, 5'd0, 32'h200, 32'hDEAD_BEEF);
      send_req(lsu_pkg::LH, lsu_pkg::ST_NONE, 5'd5, 32'h201, 32'd0);
      send_req(lsu_pkg::LHU, lsu_pkg::ST_NONE, 5'd6, 32'h203, 32'd0);
      send_req(lsu_pkg::LW, lsu_pkg::ST_NONE, 5'd7, 32'h202, 32'd0);
      send_req(lsu_pkg::LD_NONE, lsu_pkg::SW, 5'd0, 32'h203, 32'h1234_5678);
      send_req(lsu_pkg::LD_NONE, lsu_pkg::SH, 5'd0, 32'h201, 32'h0000_FFFF);
      send_req(lsu_pkg::LW, lsu_pkg::ST_NONE, 5'd8, 32'h200, 32'd0);
      drain_wrb();
      end_test();
   endtask

   task automatic test_stall;
      int sent;
      int snap;
      int waited;
      start_test("stall");
      sent         = 0;
      dmem_stall_i = 1'b1;
      // Alternate stores and loads on one word to expose reordering
      for (int i = 0; i < 16; i++) begin
         if (credit_cnt > 0) begin
            if (sent % 2 == 0) begin
               send_req(lsu_pkg::LD_NONE, lsu_pkg::SW, 5'd0, 32'h180, 32'h1111_0000 + sent);
            end else begin
               send_req(lsu_pkg::LW, lsu_pkg::ST_NONE, 5'(sent), 32'h180, 32'd0);
            end
            sent++;
         end else begin
            idle(1);
         end
      end
      snap = credit_returns;
      idle(10);
      if (credit_cnt != 0 || credit_returns != snap) begin
         $display("Credit leak in %s: credits came back while memory was stalled", cur_test);
         errors++;
      end
      if (wrb_q.size() != 0) begin
         $display("Early writeback in %s: writeback seen while memory was stalled", cur_test);
         errors++;
      end
      // Dmem buffer fills first, then the execute queue
      if (sent != (`LSU_REQ_CREDITS + `DMEM_CREDITS)) begin
         $display("Mismatch in %s: requests accepted expected %0d actual %0d",
                  cur_test, `LSU_REQ_CREDITS + `DMEM_CREDITS, sent);
         errors++;
      end
      dmem_stall_i = 1'b0;
      drain_wrb();
      waited = 0;
      while (credit_cnt != `LSU_REQ_CREDITS && waited < TIMEOUT) begin
         idle(1);
         waited++;
      end
      if (credit_cnt != `LSU_REQ_CREDITS) begin
         $display("Mismatch in %s: credits expected %0d actual %0d",
                  cur_test, `LSU_REQ_CREDITS, credit_cnt);
         errors++;
      end
      end_test();
   endtask

   task automatic test_random;
      logic [31:0]        r;
      logic [1:0]         off;
      lsu_pkg::ld_ops_e   ld;
      lsu_pkg::st_ops_e   st;
      start_test("random");
      for (int n = 0; n < 200; n++) begin
         r  = lcg_next();
         ld = lsu_pkg::LD_NONE;
         st = lsu_pkg::ST_NONE;
         case (r[2:0])
            3'd0: ld = lsu_pkg::LB;
            3'd1: ld = lsu_pkg::LBU;
            3'd2: ld = lsu_pkg::LH;
            3'd3: ld = lsu_pkg::LHU;
            3'd4: ld = lsu_pkg::LW;
            3'd5: st = lsu_pkg::SB;
            3'd6: st = lsu_pkg::SH;
            default: st = lsu_pkg::SW;
         endcase
         // Offset kept legal for the access size
         if (r[2:0] == 3'd4 || r[2:0] == 3'd7) begin
            off = 2'b00;
         end else if (r[2:0] == 3'd2 || r[2:0] == 3'd3 || r[2:0] == 3'd6) begin
            off = {r[5], 1'b0};
         end else begin
            off = r[5:4];
         end
         send_req(ld, st, r[20:16], {24'd0, 2'b11, r[11:8], off}, lcg_next());
         if (r[31:28] == 4'd0) begin
            dmem_stall_i = 1'b1;
            idle(1 + int'(r[25:24]));
            dmem_stall_i = 1'b0;
         end
      end
      drain_wrb();
      end_test();
   endtask

   initial begin
      clk_i          = 1'b0;
      rst_n_i        = 1'b0;
      exe2lsu_i      = '0;
      dmem_stall_i   = 1'b0;
      credit_cnt     = `LSU_REQ_CREDITS;
      credit_returns = 0;
      errors         = 0;
      tests_run      = 0;
      cur_test       = "init";
      lcg_state      = 32'h8a65efa6;
      bvals[0]       = 8'h7F;
      bvals[1]       = 8'h80;
      bvals[2]       = 8'h5A;
      bvals[3]       = 8'hC3;
      for (int i = 0; i < 1024; i++) begin
         ref_mem[i] = 8'h00;
      end
      repeat (8) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;

      test_reset();
      test_word();
      test_subword();
      test_misaligned();
      test_stall();
      test_random();

      $display("Summary: %0d tests run, %0d errors", tests_run, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
